// File: hdl/uart_cfg_pkg.sv
// Line settings of the UART and the standard settings loaded after reset
// or after a failed negotiation

package uart_cfg_pkg;

  // ------------------------------
  // Field encodings
  // ------------------------------

  // Number of data bits in a character
  typedef enum logic [1:0] {
    DW_5BIT = 2'b00,
    DW_6BIT = 2'b01,
    DW_7BIT = 2'b10,
    DW_8BIT = 2'b11
  } data_width_e;

  // Parity added after the data bits, code 2'b11 is unused
  typedef enum logic [1:0] {
    PAR_EVEN = 2'b00,
    PAR_ODD  = 2'b01,
    PAR_NONE = 2'b10
  } parity_mode_e;

  // Stop bits closing a character
  typedef enum logic [1:0] {
    SB_1 = 2'b00,
    SB_2 = 2'b01
  } stop_bits_e;

  // ------------------------------
  // Complete line settings
  // ------------------------------

  // Field order matches the order of the configuration packets
  typedef struct packed {
    data_width_e  data_width;
    parity_mode_e parity_mode;
    stop_bits_e   stop_bits;
  } line_cfg_t;

  // 8 data bits, even parity and 1 stop bit
  localparam line_cfg_t STD_LINE_CFG = '{
    data_width:  DW_8BIT,
    parity_mode: PAR_EVEN,
    stop_bits:   SB_1
  };

endpackage

// File: hdl/uart_proto_pkg.sv
// Packet format and controller states of the link negotiation

package uart_proto_pkg;

  // Id field of a configuration packet, sent in this order
  typedef enum logic [1:0] {
    ID_DATA_WIDTH = 2'b00,
    ID_PARITY     = 2'b01,
    ID_STOP_BITS  = 2'b10,
    ID_END        = 2'b11
  } pkt_id_e;

  // Top nibble of every configuration packet
  // Bits 3 to 2 hold the id and bits 1 to 0 hold the option
  localparam logic [3:0] PKT_MARKER = 4'b1010;

  // Word the peer returns to accept a request or a packet
  localparam logic [7:0] ACK_PKT = 8'hFF;

  // Master-side negotiation states
  typedef enum logic [2:0] {
    ST_MAIN         = 3'd0,
    ST_LINE_REQ     = 3'd1,
    ST_WAIT_REQ_ACK = 3'd2,
    ST_SEND_PKT     = 3'd3,
    ST_WAIT_TX      = 3'd4,
    ST_WAIT_PKT_ACK = 3'd5
  } neg_state_e;

endpackage

// File: hdl/cfg_ctrl_if.sv
`timescale 1ns/1ps

// Link between the negotiation FSM and the line settings register
interface cfg_ctrl_if;

  // One-cycle strobes from the FSM
  logic capture;
  logic load_std;
  logic commit;

  // Settings held by the register
  uart_cfg_pkg::line_cfg_t pending_cfg;
  uart_cfg_pkg::line_cfg_t active_cfg;

  modport neg_mp (output capture, load_std, commit, input pending_cfg, active_cfg);

  modport reg_mp (input capture, load_std, commit, output pending_cfg, active_cfg);

endinterface

// File: hdl/line_cfg_register.sv
`timescale 1ns/1ps

// Holds the settings being negotiated and the settings the line runs with
module line_cfg_register (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  uart_cfg_pkg::line_cfg_t req_cfg_i,
  cfg_ctrl_if.reg_mp              cfg_bus,
  output uart_cfg_pkg::line_cfg_t active_cfg_o
);

  uart_cfg_pkg::line_cfg_t pending_q;
  uart_cfg_pkg::line_cfg_t active_q;

  // Snapshot of the CPU request taken when a negotiation starts
  // The packets are built from this copy, so the CPU may change its
  // request lines while the exchange is still running
  always_ff @(posedge clk_i) begin
    if (cfg_bus.capture) begin
      pending_q <= req_cfg_i;
    end
  end

  // Active settings start as standard and change only on a strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= uart_cfg_pkg::STD_LINE_CFG;
    end else if (cfg_bus.load_std) begin
      active_q <= uart_cfg_pkg::STD_LINE_CFG;
    end else if (cfg_bus.commit) begin
      active_q <= pending_q;
    end
  end

  assign cfg_bus.pending_cfg = pending_q;
  assign cfg_bus.active_cfg  = active_q;
  assign active_cfg_o        = active_q;

  // ------------------------------
  // Assertions
  // ------------------------------

  // A negotiation either fails or completes, never both in one cycle
  a_load_commit_excl: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(cfg_bus.load_std && cfg_bus.commit)
  ) else $error("line_cfg_register: load_std and commit high together");

endmodule

// File: hdl/cfg_negotiator.sv
`timescale 1ns/1ps

// Master side of the link negotiation
module cfg_negotiator #(
  parameter int TIMEOUT_CYCLES = 2_500_000,
  parameter int MAX_REQ_TRIES  = 3
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cfg_req_i,
  input  logic       std_cfg_i,
  input  logic       cpu_rx_read_i,
  input  logic       cpu_tx_write_i,
  input  logic [7:0] cpu_tx_data_i,
  input  logic       line_req_done_i,
  input  logic       tx_done_i,
  input  logic       rx_empty_i,
  input  logic [7:0] rx_data_i,
  cfg_ctrl_if.neg_mp cfg_bus,
  output logic       line_req_o,
  output logic       tx_write_o,
  output logic [7:0] tx_data_o,
  output logic       rx_read_o,
  output logic       cfg_done_o,
  output logic       cfg_fail_o
);

  // Counter widths hold the last count of a window and the try limit
  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam int TRY_W = $clog2(MAX_REQ_TRIES + 1);

  uart_proto_pkg::neg_state_e state_q;
  uart_proto_pkg::neg_state_e state_d;
  logic [CNT_W-1:0]           win_cnt_q;
  logic [CNT_W-1:0]           win_cnt_d;
  logic [TRY_W-1:0]           try_cnt_q;
  logic [TRY_W-1:0]           try_cnt_d;
  uart_proto_pkg::pkt_id_e    phase_q;
  uart_proto_pkg::pkt_id_e    phase_d;
  logic                       ack_seen;
  logic                       win_expired;
  logic                       last_try;
  logic [1:0]                 pkt_option;
  logic [7:0]                 pkt_word;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= uart_proto_pkg::ST_MAIN;
      win_cnt_q <= '0;
      try_cnt_q <= '0;
      phase_q   <= uart_proto_pkg::ID_DATA_WIDTH;
    end else begin
      state_q   <= state_d;
      win_cnt_q <= win_cnt_d;
      try_cnt_q <= try_cnt_d;
      phase_q   <= phase_d;
    end
  end

  // An acknowledgement is only valid while the FIFO head holds a word
  assign ack_seen    = !rx_empty_i && (rx_data_i == uart_proto_pkg::ACK_PKT);
  assign win_expired = (win_cnt_q == CNT_W'(TIMEOUT_CYCLES - 1));
  assign last_try    = (try_cnt_q == TRY_W'(MAX_REQ_TRIES - 1));

  // ------------------------------
  // Packet assembly
  // ------------------------------

  // Option field follows the phase, the end packet carries zero
  always_comb begin
    case (phase_q)
      uart_proto_pkg::ID_DATA_WIDTH: pkt_option = cfg_bus.pending_cfg.data_width;
      uart_proto_pkg::ID_PARITY:     pkt_option = cfg_bus.pending_cfg.parity_mode;
      uart_proto_pkg::ID_STOP_BITS:  pkt_option = cfg_bus.pending_cfg.stop_bits;
      default:                       pkt_option = 2'b00;
    endcase
    pkt_word = {uart_proto_pkg::PKT_MARKER, phase_q, pkt_option};
  end

  // ------------------------------
  // Next state and outputs
  // ------------------------------

  always_comb begin
    state_d          = state_q;
    win_cnt_d        = '0;
    try_cnt_d        = try_cnt_q;
    phase_d          = phase_q;
    cfg_bus.capture  = 1'b0;
    cfg_bus.load_std = 1'b0;
    cfg_bus.commit   = 1'b0;
    line_req_o       = 1'b0;
    tx_write_o       = 1'b0;
    tx_data_o        = pkt_word;
    rx_read_o        = 1'b0;
    cfg_done_o       = 1'b0;
    cfg_fail_o       = 1'b0;

    case (state_q)
      // CPU owns both FIFOs while idle
      uart_proto_pkg::ST_MAIN: begin
        cfg_done_o = 1'b1;
        rx_read_o  = cpu_rx_read_i;
        tx_write_o = cpu_tx_write_i;
        tx_data_o  = cpu_tx_data_i;
        phase_d    = uart_proto_pkg::ID_DATA_WIDTH;
        try_cnt_d  = '0;
        if (cfg_req_i) begin
          cfg_bus.capture = 1'b1;
          state_d         = uart_proto_pkg::ST_LINE_REQ;
        end else if (std_cfg_i) begin
          cfg_bus.load_std = 1'b1;
        end
      end

      // Transmitter holds the line request until it reports completion
      uart_proto_pkg::ST_LINE_REQ: begin
        line_req_o = 1'b1;
        if (line_req_done_i) begin
          state_d = uart_proto_pkg::ST_WAIT_REQ_ACK;
        end
      end

      // Words other than the acknowledgement are popped and dropped
      uart_proto_pkg::ST_WAIT_REQ_ACK: begin
        win_cnt_d = win_cnt_q + 1'b1;
        rx_read_o = !rx_empty_i;
        if (ack_seen) begin
          state_d = uart_proto_pkg::ST_SEND_PKT;
        end else if (win_expired) begin
          if (last_try) begin
            cfg_bus.load_std = 1'b1;
            cfg_fail_o       = 1'b1;
            state_d          = uart_proto_pkg::ST_MAIN;
          end else begin
            try_cnt_d = try_cnt_q + 1'b1;
            state_d   = uart_proto_pkg::ST_LINE_REQ;
          end
        end
      end

      uart_proto_pkg::ST_SEND_PKT: begin
        tx_write_o = 1'b1;
        state_d    = uart_proto_pkg::ST_WAIT_TX;
      end

      uart_proto_pkg::ST_WAIT_TX: begin
        if (tx_done_i) begin
          state_d = uart_proto_pkg::ST_WAIT_PKT_ACK;
        end
      end

      // A single window per packet, no retry here
      uart_proto_pkg::ST_WAIT_PKT_ACK: begin
        win_cnt_d = win_cnt_q + 1'b1;
        rx_read_o = !rx_empty_i;
        if (ack_seen) begin
          if (phase_q == uart_proto_pkg::ID_END) begin
            cfg_bus.commit = 1'b1;
            state_d        = uart_proto_pkg::ST_MAIN;
          end else begin
            phase_d = uart_proto_pkg::pkt_id_e'(phase_q + 1'b1);
            state_d = uart_proto_pkg::ST_SEND_PKT;
          end
        end else if (win_expired) begin
          cfg_bus.load_std = 1'b1;
          cfg_fail_o       = 1'b1;
          state_d          = uart_proto_pkg::ST_MAIN;
        end
      end

      default: begin
        state_d = uart_proto_pkg::ST_MAIN;
      end
    endcase
  end

  // ------------------------------
  // Assertions
  // ------------------------------

  a_req_tx_excl: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(line_req_o && tx_write_o)
  ) else $error("cfg_negotiator: line request and transmit write overlap");

  // Only the CPU pass-through may be active right after reset
  a_reset_idle: assert property (
    @(posedge clk_i)
    !rst_n_i |=> !line_req_o && !cfg_fail_o && cfg_done_o && !cfg_bus.commit &&
                 (tx_write_o == cpu_tx_write_i) && (rx_read_o == cpu_rx_read_i)
  ) else $error("cfg_negotiator: control outputs active after reset");

  // A failure returns to idle with the standard settings in the register
  a_fail_to_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_fail_o |=> (state_q == uart_proto_pkg::ST_MAIN) &&
                   (cfg_bus.active_cfg == uart_cfg_pkg::STD_LINE_CFG)
  ) else $error("cfg_negotiator: failure did not restore idle with standard settings");

endmodule

// File: hdl/rx_error_unit.sv
`timescale 1ns/1ps

// Parity check of each read word and sticky receive error flags
module rx_error_unit (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  uart_cfg_pkg::line_cfg_t active_cfg_i,
  input  logic                    rx_read_i,
  input  logic [7:0]              rx_data_i,
  input  logic                    rx_parity_i,
  input  logic                    frame_error_i,
  input  logic                    overrun_error_i,
  input  logic                    cfg_fail_i,
  input  logic                    irq_ack_i,
  output logic                    err_parity_o,
  output logic                    err_frame_o,
  output logic                    err_overrun_o,
  output logic                    err_config_o
);

  // Bit positions in the flag vector
  localparam int ERR_PARITY  = 0;
  localparam int ERR_FRAME   = 1;
  localparam int ERR_OVERRUN = 2;
  localparam int ERR_CONFIG  = 3;

  logic       data_xor;
  logic       exp_parity;
  logic       parity_bad;
  logic [3:0] cause;
  logic [3:0] flags_q;

  // XOR over the bits the active width actually carries
  always_comb begin
    case (active_cfg_i.data_width)
      uart_cfg_pkg::DW_5BIT: data_xor = ^rx_data_i[4:0];
      uart_cfg_pkg::DW_6BIT: data_xor = ^rx_data_i[5:0];
      uart_cfg_pkg::DW_7BIT: data_xor = ^rx_data_i[6:0];
      default:               data_xor = ^rx_data_i;
    endcase
  end

  // Odd mode adds a one so that the total count of ones is odd
  assign exp_parity = data_xor ^ (active_cfg_i.parity_mode == uart_cfg_pkg::PAR_ODD);
  assign parity_bad = rx_read_i && (active_cfg_i.parity_mode != uart_cfg_pkg::PAR_NONE) &&
                      (exp_parity != rx_parity_i);

  assign cause = {cfg_fail_i, overrun_error_i, frame_error_i, parity_bad};

  // Acknowledge clears everything while a cause in the same cycle still sets its flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      flags_q <= '0;
    end else if (irq_ack_i) begin
      flags_q <= cause;
    end else begin
      flags_q <= flags_q | cause;
    end
  end

  assign err_parity_o  = flags_q[ERR_PARITY];
  assign err_frame_o   = flags_q[ERR_FRAME];
  assign err_overrun_o = flags_q[ERR_OVERRUN];
  assign err_config_o  = flags_q[ERR_CONFIG];

  // After an acknowledge a flag output may only be set by its own input strobe
  a_ack_clears: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    irq_ack_i |=> (!err_parity_o || $past(rx_read_i)) &&
                  (!err_frame_o || $past(frame_error_i)) &&
                  (!err_overrun_o || $past(overrun_error_i)) &&
                  (!err_config_o || $past(cfg_fail_i))
  ) else $error("rx_error_unit: flag survived an interrupt acknowledge");

endmodule

// File: hdl/uart_cfg_ctrl.sv
`timescale 1ns/1ps

// Configuration controller of the self-configuring UART
module uart_cfg_ctrl #(
  parameter int TIMEOUT_CYCLES = 2_500_000,
  parameter int MAX_REQ_TRIES  = 3
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // CPU side
  input  logic                    cfg_req_i,
  input  logic                    std_cfg_i,
  input  uart_cfg_pkg::line_cfg_t req_cfg_i,
  input  logic                    cpu_rx_read_i,
  input  logic                    cpu_tx_write_i,
  input  logic [7:0]              cpu_tx_data_i,
  // Transmitter and receiver side
  input  logic                    line_req_done_i,
  input  logic                    tx_done_i,
  input  logic                    rx_empty_i,
  input  logic [7:0]              rx_data_i,
  input  logic                    rx_parity_i,
  input  logic                    frame_error_i,
  input  logic                    overrun_error_i,
  input  logic                    irq_ack_i,
  output logic                    line_req_o,
  output logic                    tx_write_o,
  output logic [7:0]              tx_data_o,
  output logic                    rx_read_o,
  output logic                    cfg_done_o,
  output uart_cfg_pkg::line_cfg_t active_cfg_o,
  output logic                    err_parity_o,
  output logic                    err_frame_o,
  output logic                    err_overrun_o,
  output logic                    err_config_o
);

  logic cfg_fail;

  cfg_ctrl_if u_cfg_bus ();

  line_cfg_register u_line_cfg_register (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_cfg_i    (req_cfg_i),
    .cfg_bus      (u_cfg_bus.reg_mp),
    .active_cfg_o (active_cfg_o)
  );

  cfg_negotiator #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .MAX_REQ_TRIES  (MAX_REQ_TRIES)
  ) u_cfg_negotiator (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_req_i       (cfg_req_i),
    .std_cfg_i       (std_cfg_i),
    .cpu_rx_read_i   (cpu_rx_read_i),
    .cpu_tx_write_i  (cpu_tx_write_i),
    .cpu_tx_data_i   (cpu_tx_data_i),
    .line_req_done_i (line_req_done_i),
    .tx_done_i       (tx_done_i),
    .rx_empty_i      (rx_empty_i),
    .rx_data_i       (rx_data_i),
    .cfg_bus         (u_cfg_bus.neg_mp),
    .line_req_o      (line_req_o),
    .tx_write_o      (tx_write_o),
    .tx_data_o       (tx_data_o),
    .rx_read_o       (rx_read_o),
    .cfg_done_o      (cfg_done_o),
    .cfg_fail_o      (cfg_fail)
  );

  // Every word popped from the receive FIFO goes through the parity check
  rx_error_unit u_rx_error_unit (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .active_cfg_i    (active_cfg_o),
    .rx_read_i       (rx_read_o),
    .rx_data_i       (rx_data_i),
    .rx_parity_i     (rx_parity_i),
    .frame_error_i   (frame_error_i),
    .overrun_error_i (overrun_error_i),
    .cfg_fail_i      (cfg_fail),
    .irq_ack_i       (irq_ack_i),
    .err_parity_o    (err_parity_o),
    .err_frame_o     (err_frame_o),
    .err_overrun_o   (err_overrun_o),
    .err_config_o    (err_config_o)
  );

endmodule

// File: verification/tb_uart_cfg_ctrl.sv
`timescale 1ns/1ps

module tb_uart_cfg_ctrl;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 40;
  localparam int MAX_REQ_TRIES  = 3;
  localparam int NUM_ROWS       = 9;
  // Longest time one table row may take and the whole run with reset
  localparam int ROW_CYCLES     = (MAX_REQ_TRIES + 6) * (TIMEOUT_CYCLES + 20);
  localparam int RUN_CYCLES     = RESET_CYCLES + NUM_ROWS * ROW_CYCLES;
  localparam int IDLE_WORDS     = 8;

  // Row kinds
  localparam int K_NEG  = 0;
  localparam int K_IDLE = 1;
  localparam int K_STD  = 2;

  localparam uart_cfg_pkg::line_cfg_t CFG_STD = uart_cfg_pkg::STD_LINE_CFG;
  localparam uart_cfg_pkg::line_cfg_t CFG_7O2 =
    '{uart_cfg_pkg::DW_7BIT, uart_cfg_pkg::PAR_ODD, uart_cfg_pkg::SB_2};
  localparam uart_cfg_pkg::line_cfg_t CFG_5N1 =
    '{uart_cfg_pkg::DW_5BIT, uart_cfg_pkg::PAR_NONE, uart_cfg_pkg::SB_1};
  localparam uart_cfg_pkg::line_cfg_t CFG_6E2 =
    '{uart_cfg_pkg::DW_6BIT, uart_cfg_pkg::PAR_EVEN, uart_cfg_pkg::SB_2};
  localparam uart_cfg_pkg::line_cfg_t CFG_5O2 =
    '{uart_cfg_pkg::DW_5BIT, uart_cfg_pkg::PAR_ODD, uart_cfg_pkg::SB_2};
  localparam uart_cfg_pkg::line_cfg_t CFG_7E1 =
    '{uart_cfg_pkg::DW_7BIT, uart_cfg_pkg::PAR_EVEN, uart_cfg_pkg::SB_1};

  typedef struct {
    string                   name;
    int                      kind;
    uart_cfg_pkg::line_cfg_t req_cfg;
    int                      nack_windows;
    bit                      withhold;
    uart_cfg_pkg::line_cfg_t exp_cfg;
    bit                      exp_cfg_err;
  } scenario_t;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    cfg_req_i;
  logic                    std_cfg_i;
  uart_cfg_pkg::line_cfg_t req_cfg_i;
  logic                    cpu_rx_read_i;
  logic                    cpu_tx_write_i;
  logic [7:0]              cpu_tx_data_i;
  logic                    line_req_done_i;
  logic                    tx_done_i;
  logic                    rx_empty_i;
  logic [7:0]              rx_data_i;
  logic                    rx_parity_i;
  logic                    frame_error_i;
  logic                    overrun_error_i;
  logic                    irq_ack_i;
  logic                    line_req_o;
  logic                    tx_write_o;
  logic [7:0]              tx_data_o;
  logic                    rx_read_o;
  logic                    cfg_done_o;
  uart_cfg_pkg::line_cfg_t active_cfg_o;
  logic                    err_parity_o;
  logic                    err_frame_o;
  logic                    err_overrun_o;
  logic                    err_config_o;

  // Receive side is shared by the peer and the idle traffic of the CPU
  logic       idle_rx;
  logic [7:0] host_rx_data;
  logic       host_rx_par;
  logic       peer_rx_empty;
  logic [7:0] peer_rx_data;
  logic       peer_rx_par;

  // Bookkeeping of the peer that is cleared at the start of each negotiation
  int         req_rises;
  int         nack_windows;
  bit         withhold_ack;
  logic [7:0] tx_words[$];

  // Settings the line should be running with after the rows done so far
  uart_cfg_pkg::line_cfg_t exp_active_cfg;

  scenario_t rows[$];
  int        checks;
  int        errors;

  assign rx_empty_i  = idle_rx ? 1'b0 : peer_rx_empty;
  assign rx_data_i   = idle_rx ? host_rx_data : peer_rx_data;
  assign rx_parity_i = idle_rx ? host_rx_par : peer_rx_par;

  uart_cfg_ctrl #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .MAX_REQ_TRIES  (MAX_REQ_TRIES)
  ) u_uart_cfg_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_req_i       (cfg_req_i),
    .std_cfg_i       (std_cfg_i),
    .req_cfg_i       (req_cfg_i),
    .cpu_rx_read_i   (cpu_rx_read_i),
    .cpu_tx_write_i  (cpu_tx_write_i),
    .cpu_tx_data_i   (cpu_tx_data_i),
    .line_req_done_i (line_req_done_i),
    .tx_done_i       (tx_done_i),
    .rx_empty_i      (rx_empty_i),
    .rx_data_i       (rx_data_i),
    .rx_parity_i     (rx_parity_i),
    .frame_error_i   (frame_error_i),
    .overrun_error_i (overrun_error_i),
    .irq_ack_i       (irq_ack_i),
    .line_req_o      (line_req_o),
    .tx_write_o      (tx_write_o),
    .tx_data_o       (tx_data_o),
    .rx_read_o       (rx_read_o),
    .cfg_done_o      (cfg_done_o),
    .active_cfg_o    (active_cfg_o),
    .err_parity_o    (err_parity_o),
    .err_frame_o     (err_frame_o),
    .err_overrun_o   (err_overrun_o),
    .err_config_o    (err_config_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------
  // Reference rules
  // ------------------------------

  // Parity bit the sender attaches is the XOR of the carried bits plus one in odd mode
  function automatic logic line_parity(input logic [7:0] word,
                                       input uart_cfg_pkg::line_cfg_t cfg);
    int   nbits;
    logic p;
    nbits = 5 + int'(cfg.data_width);
    p = (cfg.parity_mode == uart_cfg_pkg::PAR_ODD);
    for (int b = 0; b < nbits; b++) begin
      p = p ^ word[b];
    end
    return p;
  endfunction

  // Packet holds the marker, the id in send order and the option of that id
  // The end packet carries a zero option
  function automatic logic [7:0] expected_packet(input int idx,
                                                 input uart_cfg_pkg::line_cfg_t cfg);
    logic [1:0] opt;
    case (idx)
      0: opt = cfg.data_width;
      1: opt = cfg.parity_mode;
      2: opt = cfg.stop_bits;
      default: opt = 2'b00;
    endcase
    return {uart_proto_pkg::PKT_MARKER, 2'(idx), opt};
  endfunction

  function automatic void check_value(input string name, input logic [31:0] expected,
                                      input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endfunction

  // Inputs change 2 ns after the rising edge
  task automatic advance_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic acknowledge_irq();
    advance_cycle();
    irq_ack_i = 1'b1;
    advance_cycle();
    irq_ack_i = 1'b0;
  endtask

  task automatic wait_for_idle(input string name);
    int cycles;
    cycles = 0;
    while (!cfg_done_o && cycles < ROW_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!cfg_done_o) begin
      errors++;
      $display("%s: negotiation did not return to idle within %0d cycles", name, ROW_CYCLES);
    end
  endtask

  // ------------------------------
  // Peer model
  // ------------------------------

  // Looks at the DUT mid-cycle and answers after the next rising edge
  initial begin : peer_model
    int   req_wait;
    int   tx_wait;
    int   ack_wait;
    logic req_prev;
    logic pop_seen;
    req_wait        = -1;
    tx_wait         = -1;
    ack_wait        = -1;
    req_prev        = 1'b0;
    line_req_done_i = 1'b0;
    tx_done_i       = 1'b0;
    peer_rx_empty   = 1'b1;
    peer_rx_data    = 8'h00;
    peer_rx_par     = 1'b0;
    forever begin
      @(negedge clk_i);
      pop_seen = rx_read_o && !rx_empty_i;
      if (line_req_o && !req_prev) begin
        req_rises++;
        req_wait = 1 + ($urandom % 3);
      end
      req_prev = line_req_o;
      // CPU writes in the idle state are not meant for the peer
      if (tx_write_o && !cfg_done_o) begin
        tx_words.push_back(tx_data_o);
        tx_wait = 1 + ($urandom % 4);
      end
      advance_cycle();
      line_req_done_i = 1'b0;
      tx_done_i       = 1'b0;
      if (pop_seen) begin
        peer_rx_empty = 1'b1;
      end
      // The acknowledgement carries a correct parity bit for the expected settings
      if (ack_wait == 0) begin
        peer_rx_data  = uart_proto_pkg::ACK_PKT;
        peer_rx_par   = line_parity(uart_proto_pkg::ACK_PKT, exp_active_cfg);
        peer_rx_empty = 1'b0;
      end
      if (ack_wait >= 0) begin
        ack_wait--;
      end
      if (req_wait == 0) begin
        line_req_done_i = 1'b1;
        if (req_rises > nack_windows) begin
          ack_wait = 1 + ($urandom % 3);
        end
      end
      if (req_wait >= 0) begin
        req_wait--;
      end
      // A withheld answer belongs to the third packet which carries the stop bits
      if (tx_wait == 0) begin
        tx_done_i = 1'b1;
        if (!(withhold_ack && tx_words.size() == 3)) begin
          ack_wait = 1 + ($urandom % 3);
        end
      end
      if (tx_wait >= 0) begin
        tx_wait--;
      end
    end
  end

  // ------------------------------
  // Scenario kinds
  // ------------------------------

  task automatic run_negotiation(input scenario_t row);
    int exp_rises;
    int exp_pkts;
    exp_rises = (row.nack_windows >= MAX_REQ_TRIES) ? MAX_REQ_TRIES : row.nack_windows + 1;
    if (row.nack_windows >= MAX_REQ_TRIES) begin
      exp_pkts = 0;
    end else if (row.withhold) begin
      exp_pkts = 3;
    end else begin
      exp_pkts = 4;
    end
    req_rises    = 0;
    tx_words.delete();
    nack_windows = row.nack_windows;
    withhold_ack = row.withhold;
    req_cfg_i    = row.req_cfg;
    cfg_req_i    = 1'b1;
    advance_cycle();
    cfg_req_i = 1'b0;
    // Request lines change after capture and must not reach the packets
    req_cfg_i = uart_cfg_pkg::line_cfg_t'(~row.req_cfg);
    @(negedge clk_i);
    check_value({row.name, " line_req_o"}, 1, line_req_o);
    wait_for_idle(row.name);
    check_value({row.name, " active_cfg_o"}, row.exp_cfg, active_cfg_o);
    check_value({row.name, " err_config_o"}, row.exp_cfg_err, err_config_o);
    check_value({row.name, " err_parity_o"}, 0, err_parity_o);
    check_value({row.name, " line requests"}, exp_rises, req_rises);
    check_value({row.name, " packet count"}, exp_pkts, tx_words.size());
    for (int i = 0; i < exp_pkts && i < tx_words.size(); i++) begin
      check_value($sformatf("%s packet %0d", row.name, i), expected_packet(i, row.req_cfg),
                  tx_words[i]);
    end
    exp_active_cfg = row.exp_cfg;
    if (row.exp_cfg_err) begin
      acknowledge_irq();
      @(negedge clk_i);
      check_value({row.name, " err_config_o cleared"}, 0, err_config_o);
    end
  endtask

  // CPU reads with random parity faults, error strobes and one write
  task automatic run_idle_traffic(input scenario_t row);
    logic [7:0] word;
    logic       flip;
    logic       exp_flag;
    idle_rx = 1'b1;
    for (int i = 0; i < IDLE_WORDS; i++) begin
      word          = 8'($urandom);
      flip          = 1'($urandom);
      exp_flag      = flip && (row.exp_cfg.parity_mode != uart_cfg_pkg::PAR_NONE);
      host_rx_data  = word;
      host_rx_par   = line_parity(word, row.exp_cfg) ^ flip;
      cpu_rx_read_i = 1'b1;
      @(negedge clk_i);
      check_value($sformatf("%s rx_read_o %0d", row.name, i), 1, rx_read_o);
      advance_cycle();
      cpu_rx_read_i = 1'b0;
      @(negedge clk_i);
      check_value($sformatf("%s err_parity_o %0d", row.name, i), exp_flag, err_parity_o);
      acknowledge_irq();
    end
    frame_error_i = 1'b1;
    advance_cycle();
    frame_error_i   = 1'b0;
    overrun_error_i = 1'b1;
    @(negedge clk_i);
    check_value({row.name, " err_frame_o"}, 1, err_frame_o);
    advance_cycle();
    overrun_error_i = 1'b0;
    cpu_tx_write_i  = 1'b1;
    cpu_tx_data_i   = 8'($urandom);
    @(negedge clk_i);
    check_value({row.name, " err_overrun_o"}, 1, err_overrun_o);
    check_value({row.name, " tx_write_o"}, 1, tx_write_o);
    check_value({row.name, " tx_data_o"}, cpu_tx_data_i, tx_data_o);
    advance_cycle();
    cpu_tx_write_i = 1'b0;
    idle_rx        = 1'b0;
    acknowledge_irq();
    @(negedge clk_i);
    check_value({row.name, " flags cleared"}, 0,
                {err_parity_o, err_frame_o, err_overrun_o, err_config_o});
    check_value({row.name, " active_cfg_o"}, row.exp_cfg, active_cfg_o);
  endtask

  task automatic run_std_reload(input scenario_t row);
    std_cfg_i = 1'b1;
    advance_cycle();
    std_cfg_i = 1'b0;
    @(negedge clk_i);
    check_value({row.name, " active_cfg_o"}, row.exp_cfg, active_cfg_o);
    exp_active_cfg = row.exp_cfg;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin : stimulus
    void'($urandom(32'ha5fc));
    checks          = 0;
    errors          = 0;
    rst_n_i         = 1'b0;
    cfg_req_i       = 1'b0;
    std_cfg_i       = 1'b0;
    req_cfg_i       = CFG_STD;
    cpu_rx_read_i   = 1'b0;
    cpu_tx_write_i  = 1'b0;
    cpu_tx_data_i   = 8'h00;
    frame_error_i   = 1'b0;
    overrun_error_i = 1'b0;
    irq_ack_i       = 1'b0;
    idle_rx         = 1'b0;
    host_rx_data    = 8'h00;
    host_rx_par     = 1'b0;
    req_rises       = 0;
    nack_windows    = 0;
    withhold_ack    = 1'b0;
    exp_active_cfg  = CFG_STD;

    // Name, kind, request, unanswered windows, withhold, expected settings, config error
    rows.push_back('{"neg_7o2",     K_NEG,  CFG_7O2, 0, 1'b0, CFG_7O2, 1'b0});
    rows.push_back('{"idle_7o2",    K_IDLE, CFG_STD, 0, 1'b0, CFG_7O2, 1'b0});
    rows.push_back('{"std_reload",  K_STD,  CFG_STD, 0, 1'b0, CFG_STD, 1'b0});
    rows.push_back('{"retry1_5n1",  K_NEG,  CFG_5N1, 1, 1'b0, CFG_5N1, 1'b0});
    rows.push_back('{"idle_5n1",    K_IDLE, CFG_STD, 0, 1'b0, CFG_5N1, 1'b0});
    rows.push_back('{"retry2_6e2",  K_NEG,  CFG_6E2, 2, 1'b0, CFG_6E2, 1'b0});
    rows.push_back('{"no_answer",   K_NEG,  CFG_5O2, 3, 1'b0, CFG_STD, 1'b1});
    rows.push_back('{"pkt_timeout", K_NEG,  CFG_7E1, 0, 1'b1, CFG_STD, 1'b1});
    rows.push_back('{"idle_std",    K_IDLE, CFG_STD, 0, 1'b0, CFG_STD, 1'b0});

    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("reset active_cfg_o", CFG_STD, active_cfg_o);
    check_value("reset cfg_done_o", 1, cfg_done_o);
    check_value("reset strobes", 0, {line_req_o, tx_write_o, rx_read_o});
    check_value("reset flags", 0, {err_parity_o, err_frame_o, err_overrun_o, err_config_o});

    foreach (rows[r]) begin
      // Each row starts driving just after a rising edge
      advance_cycle();
      case (rows[r].kind)
        K_NEG:   run_negotiation(rows[r]);
        K_IDLE:  run_idle_traffic(rows[r]);
        default: run_std_reload(rows[r]);
      endcase
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (RUN_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

// File: project.f
hdl/uart_cfg_pkg.sv
hdl/uart_proto_pkg.sv
hdl/cfg_ctrl_if.sv
hdl/line_cfg_register.sv
hdl/cfg_negotiator.sv
hdl/rx_error_unit.sv
hdl/uart_cfg_ctrl.sv
verification/tb_uart_cfg_ctrl.sv

// File: Makefile
SIM        := verilator
TOP        := tb_uart_cfg_ctrl
FILELIST   := project.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := No errors

SOURCES    := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
